// File: oflow_unit.f
+incdir+logic
logic/oflow_pkg.sv
logic/oflow_event_decode.sv
logic/oflow_count_tables.sv
logic/oflow_event_queue.sv
logic/oflow_report_writer.sv
logic/oflow_unit.sv
dv/oflow_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the overflow tracker testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=oflow_unit_sim

verilator --binary -Wno-fatal -f oflow_unit.f --top-module oflow_unit_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: dv/oflow_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_unit_tb;

	localparam logic [31:0] SEED = 32'h6de9_6ceb;
	localparam int RANDOM_CYCLES = 2000;
	localparam int MAX_CYCLES = 4000; // About 3000 cycles of tests plus margin.
	localparam int QUEUE_LIMIT = 12; // Keeps both DUT queues below full.
	localparam int DRAIN_LIMIT = 400; // Longest wait for pending reports to reach the bus.
	localparam int REC_W = $bits(oflow_pkg::oflow_report_t);

	logic clk;
	logic reset;
	logic count_inc;
	logic count_dec;
	logic count_inc_logical_core;
	oflow_pkg::task_id_t count_inc_task;
	oflow_pkg::task_id_t count_dec_task;
	oflow_pkg::core_id_t count_inc_core;
	logic csr_maxcount_write;
	logic [`OFLOW_DATA_WIDTH-1:0] csr_maxcount_writedata;
	oflow_pkg::task_mask_t checkin_in;
	oflow_pkg::task_mask_t checkin_out;
	logic oflow_waitrequest;
	logic oflow_write;
	logic [`OFLOW_ADDR_WIDTH-1:0] oflow_address;
	logic [`OFLOW_DATA_WIDTH-1:0] oflow_writedata;

	// Model state.
	oflow_pkg::count_t m_count_0 [`OFLOW_KEY_SIZE];
	oflow_pkg::count_t m_count_1 [`OFLOW_KEY_SIZE];
	oflow_pkg::count_t m_max [`OFLOW_KEY_SIZE];
	oflow_pkg::core_id_t m_core [`OFLOW_KEY_SIZE];
	oflow_pkg::task_mask_t m_status;
	oflow_pkg::oflow_report_t exp_ovf [$];
	oflow_pkg::oflow_report_t exp_unf [$];

	logic [1:0] wait_mode; // 0 never stalls, 1 stalls at random, 2 stalls always.
	logic prev_stall;
	logic [`OFLOW_ADDR_WIDTH-1:0] prev_address;
	logic [`OFLOW_DATA_WIDTH-1:0] prev_data;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int ovf_writes = 0;
	int unf_writes = 0;
	int ovf_base = 0;
	int unf_base = 0;

	oflow_unit i_oflow_unit (
		.clk(clk), .reset(reset), .count_inc(count_inc), .count_dec(count_dec),
		.count_inc_logical_core(count_inc_logical_core),
		.count_inc_task(count_inc_task), .count_dec_task(count_dec_task),
		.count_inc_core(count_inc_core), .csr_maxcount_write(csr_maxcount_write),
		.csr_maxcount_writedata(csr_maxcount_writedata), .checkin_in(checkin_in),
		.checkin_out(checkin_out), .oflow_waitrequest(oflow_waitrequest),
		.oflow_write(oflow_write), .oflow_address(oflow_address),
		.oflow_writedata(oflow_writedata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// **************************************************
	// Reporting helpers
	// **************************************************

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// **************************************************
	// Reference model
	// **************************************************

	task automatic reset_model();
		for (int i = 0; i < `OFLOW_KEY_SIZE; i++) begin
			m_count_0[i] = '0;
			m_count_1[i] = '0;
			m_max[i] = '1;
			m_core[i] = '0;
		end
		m_status = '0;
		exp_ovf.delete();
		exp_unf.delete();
	endtask

	// One cycle of the counting rules on the inputs now applied.
	function automatic oflow_pkg::task_mask_t model_step(output logic ovf_hit,
		output oflow_pkg::oflow_report_t ovf_rec, output logic unf_hit,
		output oflow_pkg::oflow_report_t unf_rec);
		oflow_pkg::task_mask_t mask;
		oflow_pkg::count_t inc_new;
		oflow_pkg::count_t new_0;
		oflow_pkg::count_t new_1;
		logic collide;
		logic inc_0;
		logic inc_1;
		logic dec_0;
		logic dec_1;
		mask = checkin_in & ~m_status; // Status before this cycle's edge.
		collide = count_inc && count_dec && (count_inc_task == count_dec_task);
		inc_0 = count_inc && !count_inc_logical_core && !collide;
		inc_1 = count_inc && count_inc_logical_core && !collide;
		dec_0 = count_dec && !(collide && !count_inc_logical_core);
		dec_1 = count_dec && !(collide && count_inc_logical_core);
		ovf_hit = 1'b0;
		unf_hit = 1'b0;
		ovf_rec = '0;
		unf_rec = '0;
		if (inc_0 || inc_1) begin
			inc_new = (inc_0 ? m_count_0[count_inc_task] : m_count_1[count_inc_task]) + 1'b1;
			if (inc_0) m_count_0[count_inc_task] = inc_new;
			else m_count_1[count_inc_task] = inc_new;
			if (inc_new >= m_max[count_inc_task] && !m_status[count_inc_task]) begin
				ovf_hit = 1'b1;
				ovf_rec.is_overflow = 1'b1;
				ovf_rec.core = count_inc_core;
				ovf_rec.task_id = count_inc_task;
				m_status[count_inc_task] = 1'b1;
				m_core[count_inc_task] = count_inc_core;
			end
		end
		if (dec_0 || dec_1) begin
			new_0 = m_count_0[count_dec_task];
			new_1 = m_count_1[count_dec_task];
			if (dec_0 && new_0 != '0) new_0 = new_0 - 1'b1; // Saturates at zero.
			if (dec_1 && new_1 != '0) new_1 = new_1 - 1'b1;
			m_count_0[count_dec_task] = new_0;
			m_count_1[count_dec_task] = new_1;
			if (new_0 == '0 && new_1 == '0 && m_status[count_dec_task]) begin
				unf_hit = 1'b1;
				unf_rec.core = m_core[count_dec_task];
				unf_rec.task_id = count_dec_task;
				m_status[count_dec_task] = 1'b0;
				m_core[count_dec_task] = '0;
			end
		end
		if (csr_maxcount_write) begin
			m_max[csr_maxcount_writedata[`OFLOW_COUNT_WIDTH +: `OFLOW_KEY_WIDTH]] =
				csr_maxcount_writedata[`OFLOW_COUNT_WIDTH-1:0];
		end
		return mask;
	endfunction

	// **************************************************
	// Checkers and bus responder
	// **************************************************

	task automatic check_write();
		logic [`OFLOW_DATA_WIDTH-1:0] raw;
		oflow_pkg::oflow_report_t rec;
		oflow_pkg::oflow_report_t exp_rec;
		raw = oflow_writedata - `OFLOW_REPORT_MARKER;
		rec = raw[REC_W-1:0];
		if (rec.is_overflow && exp_ovf.size() == 0) begin
			report_problem("overflow write arrived while no overflow report was pending");
			return;
		end
		if (!rec.is_overflow && exp_unf.size() == 0) begin
			report_problem("underflow write arrived while no underflow report was pending");
			return;
		end
		if (rec.is_overflow) begin
			exp_rec = exp_ovf.pop_front();
			ovf_writes++;
		end else begin
			exp_rec = exp_unf.pop_front();
			unf_writes++;
		end
		checks++;
		if (oflow_address !== `OFLOW_REPORT_BASE + (32'(exp_rec.core) << 20)) begin
			report_mismatch("oflow_address", `OFLOW_REPORT_BASE + (32'(exp_rec.core) << 20),
				oflow_address);
		end
		if (oflow_writedata !== `OFLOW_REPORT_MARKER + 32'(exp_rec)) begin
			report_mismatch("oflow_writedata", `OFLOW_REPORT_MARKER + 32'(exp_rec), oflow_writedata);
		end
	endtask

	always @(negedge clk) begin
		oflow_pkg::task_mask_t exp_mask;
		oflow_pkg::oflow_report_t ovf_rec;
		oflow_pkg::oflow_report_t unf_rec;
		logic ovf_hit;
		logic unf_hit;
		if (reset) begin
			reset_model();
			prev_stall = 1'b0;
		end else begin
			if (prev_stall) begin
				checks++;
				if (!oflow_write) begin
					report_problem("oflow_write dropped while oflow_waitrequest was high");
				end
				if (oflow_write && oflow_address !== prev_address) begin
					report_mismatch("oflow_address", prev_address, oflow_address);
				end
				if (oflow_write && oflow_writedata !== prev_data) begin
					report_mismatch("oflow_writedata", prev_data, oflow_writedata);
				end
			end
			if (oflow_write && !oflow_waitrequest) check_write(); // Accepted at the next edge.
			prev_stall = oflow_write && oflow_waitrequest;
			prev_address = oflow_address;
			prev_data = oflow_writedata;
			exp_mask = model_step(ovf_hit, ovf_rec, unf_hit, unf_rec);
			checks++;
			if (checkin_out !== exp_mask) report_mismatch("checkin_out", exp_mask, checkin_out);
			if (ovf_hit) exp_ovf.push_back(ovf_rec);
			if (unf_hit) exp_unf.push_back(unf_rec);
		end
	end

	always @(posedge clk) begin
		if (wait_mode == 2'd2) oflow_waitrequest <= 1'b1;
		else if (wait_mode == 2'd1) oflow_waitrequest <= ($urandom % 2) == 0;
		else oflow_waitrequest <= 1'b0;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with reports still outstanding", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	// **************************************************
	// Stimulus
	// **************************************************

	function automatic logic [`OFLOW_DATA_WIDTH-1:0] csr_word(input int task_num, input int value);
		logic [`OFLOW_DATA_WIDTH-1:0] data;
		data = '0;
		data[`OFLOW_COUNT_WIDTH +: `OFLOW_KEY_WIDTH] = task_num[`OFLOW_KEY_WIDTH-1:0];
		data[`OFLOW_COUNT_WIDTH-1:0] = value[`OFLOW_COUNT_WIDTH-1:0];
		return data;
	endfunction

	task automatic drive_counts(input logic inc, input logic lcore, input int inc_task,
		input int core, input logic dec, input int dec_task);
		@(posedge clk);
		count_inc <= inc;
		count_inc_logical_core <= lcore;
		count_inc_task <= oflow_pkg::task_id_t'(inc_task);
		count_inc_core <= oflow_pkg::core_id_t'(core);
		count_dec <= dec;
		count_dec_task <= oflow_pkg::task_id_t'(dec_task);
		csr_maxcount_write <= 1'b0;
	endtask

	task automatic program_max(input int task_num, input int value);
		@(posedge clk);
		count_inc <= 1'b0;
		count_dec <= 1'b0;
		csr_maxcount_write <= 1'b1;
		csr_maxcount_writedata <= csr_word(task_num, value);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		drive_counts(0, 0, 0, 0, 0, 0);
		repeat (3) @(posedge clk);
		while ((exp_ovf.size() != 0 || exp_unf.size() != 0 || oflow_write) &&
			waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
	endtask

	task automatic check_writes(input int ovf_exp, input int unf_exp);
		checks++;
		if (ovf_writes - ovf_base != ovf_exp) begin
			report_mismatch("overflow write count", ovf_exp, ovf_writes - ovf_base);
		end
		if (unf_writes - unf_base != unf_exp) begin
			report_mismatch("underflow write count", unf_exp, unf_writes - unf_base);
		end
		ovf_base = ovf_writes;
		unf_base = unf_writes;
	endtask

	task automatic run_random();
		logic inc;
		logic dec;
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(posedge clk);
			inc = (($urandom % 2) == 0) && (exp_ovf.size() < QUEUE_LIMIT);
			dec = (($urandom % 3) == 0) && (exp_unf.size() < QUEUE_LIMIT);
			count_inc <= inc;
			count_dec <= dec;
			count_inc_logical_core <= ($urandom % 2) == 0;
			count_inc_task <= oflow_pkg::task_id_t'($urandom);
			count_dec_task <= oflow_pkg::task_id_t'($urandom);
			count_inc_core <= oflow_pkg::core_id_t'($urandom);
			csr_maxcount_write <= ($urandom % 32) == 0;
			csr_maxcount_writedata <= csr_word($urandom % 16, 1 + $urandom % 8);
			checkin_in <= oflow_pkg::task_mask_t'($urandom);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		count_inc = 1'b0;
		count_dec = 1'b0;
		count_inc_logical_core = 1'b0;
		count_inc_task = '0;
		count_dec_task = '0;
		count_inc_core = '0;
		csr_maxcount_write = 1'b0;
		csr_maxcount_writedata = '0;
		checkin_in = '1;
		oflow_waitrequest = 1'b0;
		wait_mode = 2'd1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		program_max(5, 3);
		repeat (3) drive_counts(1, 0, 5, 9, 0, 0); // Physical core 9 causes the overflow.
		wait_drain();
		check_writes(1, 0);
		finish_test("test 1 overflow on third increment");

		repeat (2) drive_counts(1, 0, 5, 9, 0, 0);
		drive_counts(0, 0, 0, 0, 0, 0);
		@(negedge clk);
		checks++;
		if (checkin_out[5] !== 1'b0) begin
			report_mismatch("checkin_out[5]", 0, checkin_out[5]);
		end
		wait_drain();
		check_writes(0, 0);
		finish_test("test 2 no writes while in overflow");

		repeat (5) drive_counts(0, 0, 0, 0, 1, 5); // Core 0 holds 5, core 1 holds 0.
		wait_drain();
		check_writes(0, 1);
		@(negedge clk);
		checks++;
		if (checkin_out[5] !== 1'b1) report_mismatch("checkin_out[5]", 1, checkin_out[5]);
		finish_test("test 3 underflow after both counts reach zero");

		program_max(7, 4);
		drive_counts(1, 0, 7, 3, 0, 0);
		repeat (2) drive_counts(1, 1, 7, 3, 0, 0);
		drive_counts(1, 1, 7, 3, 1, 7); // Core 1 stays at 2, core 0 drops to 0.
		drive_counts(1, 1, 7, 3, 0, 0);
		wait_drain();
		check_writes(0, 0);
		drive_counts(1, 1, 7, 3, 0, 0);
		wait_drain();
		check_writes(1, 0);
		repeat (4) drive_counts(0, 0, 0, 0, 1, 7);
		wait_drain();
		check_writes(0, 1);
		finish_test("test 4 collision cancels the incrementing core");

		wait_mode <= 2'd2;
		for (int t = 0; t < 4; t++) program_max(t, 1);
		for (int t = 0; t < 4; t++) drive_counts(1, 0, t, 4 + t, 0, 0);
		drive_counts(0, 0, 0, 0, 0, 0);
		repeat (60) @(posedge clk);
		@(negedge clk);
		checks++;
		if (oflow_write !== 1'b1) report_mismatch("oflow_write", 1, oflow_write);
		for (int t = 0; t < 4; t++) drive_counts(0, 0, 0, 0, 1, t);
		drive_counts(0, 0, 0, 0, 0, 0);
		repeat (20) @(posedge clk);
		wait_mode <= 2'd0;
		wait_drain();
		check_writes(4, 4);
		finish_test("test 5 long stall keeps queued reports");

		wait_mode <= 2'd1;
		for (int t = 0; t < `OFLOW_KEY_SIZE; t++) program_max(t, 1 + $urandom % 8);
		run_random();
		checkin_in <= '1;
		wait_mode <= 2'd0;
		wait_drain();
		checks++;
		if (exp_ovf.size() != 0 || exp_unf.size() != 0) begin
			report_problem("expected reports were never written");
		end
		finish_test("test 6 random traffic");

		$display("Checks: %0d, errors: %0d, overflow writes: %0d, underflow writes: %0d",
			checks, errors, ovf_writes, unf_writes);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/oflow_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_unit (
	input wire logic clk,
	input wire logic reset,
	input wire logic count_inc,
	input wire logic count_dec,
	input wire logic count_inc_logical_core,
	input wire oflow_pkg::task_id_t count_inc_task,
	input wire oflow_pkg::task_id_t count_dec_task,
	input wire oflow_pkg::core_id_t count_inc_core,
	input wire logic csr_maxcount_write,
	input wire logic [`OFLOW_DATA_WIDTH-1:0] csr_maxcount_writedata,
	input wire oflow_pkg::task_mask_t checkin_in,
	output oflow_pkg::task_mask_t checkin_out,
	input wire logic oflow_waitrequest,
	output logic oflow_write,
	output logic [`OFLOW_ADDR_WIDTH-1:0] oflow_address,
	output logic [`OFLOW_DATA_WIDTH-1:0] oflow_writedata
);

	oflow_pkg::count_cmd_t cmd;
	oflow_pkg::maxcount_cmd_t maxcount;
	oflow_pkg::oflow_report_t ovf_record;
	oflow_pkg::oflow_report_t unf_record;
	oflow_pkg::oflow_report_t ovf_head;
	oflow_pkg::oflow_report_t unf_head;
	logic ovf_push;
	logic unf_push;
	logic ovf_pop;
	logic unf_pop;
	logic ovf_empty;
	logic unf_empty;
	logic ovf_full;
	logic unf_full;

	oflow_event_decode i_event_decode (
		.count_inc(count_inc), .count_dec(count_dec),
		.count_inc_logical_core(count_inc_logical_core),
		.count_inc_task(count_inc_task), .count_dec_task(count_dec_task),
		.count_inc_core(count_inc_core), .csr_maxcount_write(csr_maxcount_write),
		.csr_maxcount_writedata(csr_maxcount_writedata), .cmd(cmd), .maxcount(maxcount)
	);

	oflow_count_tables i_count_tables (
		.clk(clk), .reset(reset), .cmd(cmd), .maxcount(maxcount),
		.ovf_full(ovf_full), .unf_full(unf_full),
		.checkin_in(checkin_in), .checkin_out(checkin_out),
		.ovf_push(ovf_push), .unf_push(unf_push),
		.ovf_record(ovf_record), .unf_record(unf_record)
	);

	oflow_event_queue ovf_queue (
		.clk(clk), .reset(reset), .push(ovf_push), .pop(ovf_pop), .push_record(ovf_record),
		.head(ovf_head), .empty(ovf_empty), .full(ovf_full)
	);

	oflow_event_queue unf_queue (
		.clk(clk), .reset(reset), .push(unf_push), .pop(unf_pop), .push_record(unf_record),
		.head(unf_head), .empty(unf_empty), .full(unf_full)
	);

	oflow_report_writer i_report_writer (
		.clk(clk), .reset(reset),
		.ovf_empty(ovf_empty), .unf_empty(unf_empty),
		.ovf_head(ovf_head), .unf_head(unf_head),
		.ovf_pop(ovf_pop), .unf_pop(unf_pop),
		.oflow_waitrequest(oflow_waitrequest), .oflow_write(oflow_write),
		.oflow_address(oflow_address), .oflow_writedata(oflow_writedata)
	);

endmodule

`default_nettype wire

// File: logic/oflow_report_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_report_writer (
	input wire logic clk,
	input wire logic reset,
	input wire logic ovf_empty,
	input wire logic unf_empty,
	input wire oflow_pkg::oflow_report_t ovf_head,
	input wire oflow_pkg::oflow_report_t unf_head,
	output logic ovf_pop,
	output logic unf_pop,
	input wire logic oflow_waitrequest,
	output logic oflow_write,
	output logic [`OFLOW_ADDR_WIDTH-1:0] oflow_address,
	output logic [`OFLOW_DATA_WIDTH-1:0] oflow_writedata
);

	localparam int CORE_SHIFT = 20;

	oflow_pkg::writer_state_t state;
	oflow_pkg::writer_state_t next_state;
	logic serve_ovf; // Set while an overflow record is being handled.
	oflow_pkg::oflow_report_t report;

	// **************************************************
	// Writer FSM
	// **************************************************

	always_comb begin
		next_state = state;
		unique case (state)
			oflow_pkg::wr_idle: begin
				if (!ovf_empty || !unf_empty) begin
					next_state = oflow_pkg::wr_pop;
				end
			end
			oflow_pkg::wr_pop: next_state = oflow_pkg::wr_load;
			oflow_pkg::wr_load: next_state = oflow_pkg::wr_write;
			oflow_pkg::wr_write: begin
				if (!oflow_waitrequest) begin
					next_state = oflow_pkg::wr_idle; // Accepted by the bus.
				end
			end
			default: next_state = oflow_pkg::wr_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= oflow_pkg::wr_idle;
			serve_ovf <= 1'b0;
		end else begin
			state <= next_state;
			if (state == oflow_pkg::wr_idle) begin
				serve_ovf <= ~ovf_empty; // Overflow reports go first.
			end
		end
	end

	assign ovf_pop = (state == oflow_pkg::wr_pop) & serve_ovf;
	assign unf_pop = (state == oflow_pkg::wr_pop) & ~serve_ovf;

	// The head is taken on the same edge that pops it, ready in load.
	always_ff @(posedge clk) begin
		if (state == oflow_pkg::wr_pop) begin
			report <= serve_ovf ? ovf_head : unf_head;
		end
	end

	// **************************************************
	// Bus outputs
	// **************************************************

	// The report only changes in pop, so address and data hold through a stall.
	assign oflow_write = (state == oflow_pkg::wr_write);
	assign oflow_address = `OFLOW_REPORT_BASE +
		(`OFLOW_ADDR_WIDTH'(report.core) << CORE_SHIFT);
	assign oflow_writedata = `OFLOW_REPORT_MARKER + `OFLOW_DATA_WIDTH'(report);

endmodule

`default_nettype wire

// File: logic/oflow_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_event_queue (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire logic pop,
	input wire oflow_pkg::oflow_report_t push_record,
	output oflow_pkg::oflow_report_t head,
	output logic empty,
	output logic full
);

	localparam int DEPTH = `OFLOW_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	oflow_pkg::oflow_report_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop_ok;

	assign pop_ok = pop & ~empty; // Pops on an empty queue are dropped.
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_record;
		end
	end

	// **************************************************
	// Pointers and occupancy
	// **************************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			unique case ({push, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither leave the level alone.
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/oflow_count_tables.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_count_tables (
	input wire logic clk,
	input wire logic reset,
	input wire oflow_pkg::count_cmd_t cmd,
	input wire oflow_pkg::maxcount_cmd_t maxcount,
	input wire logic ovf_full,
	input wire logic unf_full,
	input wire oflow_pkg::task_mask_t checkin_in,
	output oflow_pkg::task_mask_t checkin_out,
	output logic ovf_push,
	output logic unf_push,
	output oflow_pkg::oflow_report_t ovf_record,
	output oflow_pkg::oflow_report_t unf_record
);

	localparam oflow_pkg::count_t ONE = oflow_pkg::count_t'(1);

	oflow_pkg::count_t count_0 [`OFLOW_KEY_SIZE]; // Logical core 0.
	oflow_pkg::count_t count_1 [`OFLOW_KEY_SIZE]; // Logical core 1.
	oflow_pkg::count_t max_table [`OFLOW_KEY_SIZE];
	oflow_pkg::core_id_t core_table [`OFLOW_KEY_SIZE];
	oflow_pkg::task_mask_t ovf_status;

	oflow_pkg::count_t inc_cnt_0;
	oflow_pkg::count_t inc_cnt_1;
	oflow_pkg::count_t dec_cnt_0;
	oflow_pkg::count_t dec_cnt_1;
	oflow_pkg::count_t inc_cnt;
	oflow_pkg::count_t inc_next;
	oflow_pkg::count_t dec_next_0;
	oflow_pkg::count_t dec_next_1;
	oflow_pkg::count_t max_inc;
	logic inc_any;
	logic dec_any;

	// **************************************************
	// Table reads and next counts
	// **************************************************

	assign inc_cnt_0 = count_0[cmd.inc_task];
	assign inc_cnt_1 = count_1[cmd.inc_task];
	assign dec_cnt_0 = count_0[cmd.dec_task];
	assign dec_cnt_1 = count_1[cmd.dec_task];
	assign max_inc = max_table[cmd.inc_task];

	assign inc_any = cmd.inc_0 | cmd.inc_1; // At most one core increments per cycle.
	assign dec_any = cmd.dec_0 | cmd.dec_1;
	assign inc_cnt = cmd.inc_1 ? inc_cnt_1 : inc_cnt_0;
	assign inc_next = inc_cnt + ONE;

	// Decrements stop at zero.
	always_comb begin
		dec_next_0 = dec_cnt_0;
		dec_next_1 = dec_cnt_1;
		if (cmd.dec_0 && dec_cnt_0 != '0) begin
			dec_next_0 = dec_cnt_0 - ONE;
		end
		if (cmd.dec_1 && dec_cnt_1 != '0) begin
			dec_next_1 = dec_cnt_1 - ONE;
		end
	end

	// **************************************************
	// Overflow and underflow detection
	// **************************************************

	// A full queue holds the status change back, so no report is dropped.
	assign ovf_push = inc_any & (inc_next >= max_inc) & ~ovf_status[cmd.inc_task] & ~ovf_full;

	// With a collision only decrements touch dec_task, so the next counts are exact.
	assign unf_push = dec_any & (dec_next_0 == '0) & (dec_next_1 == '0) &
		ovf_status[cmd.dec_task] & ~unf_full;

	assign ovf_record.is_overflow = 1'b1;
	assign ovf_record.core = cmd.inc_core; // Physical core that caused it.
	assign ovf_record.task_id = cmd.inc_task;

	assign unf_record.is_overflow = 1'b0;
	assign unf_record.core = core_table[cmd.dec_task]; // Stored at overflow time.
	assign unf_record.task_id = cmd.dec_task;

	// Tasks in overflow no longer check in toward the comparator.
	assign checkin_out = checkin_in & ~ovf_status;

	// **************************************************
	// Table updates
	// **************************************************

	// Increment and decrement of one core never hit the same task in one cycle.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `OFLOW_KEY_SIZE; i++) begin
				count_0[i] <= '0;
				count_1[i] <= '0;
			end
		end else begin
			if (cmd.inc_0) begin
				count_0[cmd.inc_task] <= inc_next;
			end
			if (cmd.dec_0) begin
				count_0[cmd.dec_task] <= dec_next_0;
			end
			if (cmd.inc_1) begin
				count_1[cmd.inc_task] <= inc_next;
			end
			if (cmd.dec_1) begin
				count_1[cmd.dec_task] <= dec_next_1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `OFLOW_KEY_SIZE; i++) begin
				max_table[i] <= '1; // Largest limit until software sets one.
			end
		end else if (maxcount.write) begin
			max_table[maxcount.task_id] <= maxcount.value;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ovf_status <= '0;
		end else begin
			if (ovf_push) begin
				ovf_status[cmd.inc_task] <= 1'b1;
			end
			if (unf_push) begin
				ovf_status[cmd.dec_task] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ovf_push) begin
			core_table[cmd.inc_task] <= cmd.inc_core;
		end
		if (unf_push) begin
			core_table[cmd.dec_task] <= '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/oflow_event_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "oflow_config.svh"

module oflow_event_decode (
	input wire logic count_inc,
	input wire logic count_dec,
	input wire logic count_inc_logical_core,
	input wire oflow_pkg::task_id_t count_inc_task,
	input wire oflow_pkg::task_id_t count_dec_task,
	input wire oflow_pkg::core_id_t count_inc_core,
	input wire logic csr_maxcount_write,
	input wire logic [`OFLOW_DATA_WIDTH-1:0] csr_maxcount_writedata,
	output oflow_pkg::count_cmd_t cmd,
	output oflow_pkg::maxcount_cmd_t maxcount
);

	localparam int COUNT_LSB = `OFLOW_COUNT_WIDTH;
	localparam int TASK_MSB = `OFLOW_COUNT_WIDTH + `OFLOW_KEY_WIDTH - 1;

	logic same_task;
	logic collide;
	logic cancel_0;
	logic cancel_1;

	// **************************************************
	// Collision cancelling
	// **************************************************

	assign same_task = (count_inc_task == count_dec_task);
	assign collide = count_inc & count_dec & same_task; // Both strobes hit one task.

	// The incrementing core would add one and take one away, so it does neither.
	assign cancel_0 = collide & ~count_inc_logical_core;
	assign cancel_1 = collide & count_inc_logical_core;

	assign cmd.inc_0 = count_inc & ~count_inc_logical_core & ~collide;
	assign cmd.inc_1 = count_inc & count_inc_logical_core & ~collide;
	assign cmd.dec_0 = count_dec & ~cancel_0; // The other core still decrements.
	assign cmd.dec_1 = count_dec & ~cancel_1;

	assign cmd.inc_task = count_inc_task;
	assign cmd.dec_task = count_dec_task;
	assign cmd.inc_core = count_inc_core;

	// **************************************************
	// Maximum-count register write
	// **************************************************

	// Task ID sits right above the count field.
	assign maxcount.write = csr_maxcount_write;
	assign maxcount.task_id = csr_maxcount_writedata[TASK_MSB:COUNT_LSB];
	assign maxcount.value = csr_maxcount_writedata[COUNT_LSB-1:0];

endmodule

`default_nettype wire

// File: logic/oflow_pkg.sv
`default_nettype none

`include "oflow_config.svh"

package oflow_pkg;

	typedef logic [`OFLOW_KEY_WIDTH-1:0] task_id_t;
	typedef logic [`OFLOW_KEY_WIDTH-1:0] core_id_t;
	typedef logic [`OFLOW_COUNT_WIDTH-1:0] count_t;
	typedef logic [`OFLOW_KEY_SIZE-1:0] task_mask_t;

	// Per-core counter commands after collision cancelling.
	typedef struct packed {
		logic inc_0;
		logic inc_1;
		logic dec_0;
		logic dec_1;
		task_id_t inc_task;
		task_id_t dec_task;
		core_id_t inc_core;
	} count_cmd_t;

	typedef struct packed {
		logic write;
		task_id_t task_id;
		count_t value;
	} maxcount_cmd_t;

	// The flag sits in the top bit so it lands on top of the written data.
	typedef struct packed {
		logic is_overflow;
		core_id_t core;
		task_id_t task_id;
	} oflow_report_t;

	typedef enum logic [1:0] {
		wr_idle,
		wr_pop,
		wr_load,
		wr_write
	} writer_state_t;

endpackage

`default_nettype wire

// File: logic/oflow_config.svh
`ifndef OFLOW_CONFIG_SVH
`define OFLOW_CONFIG_SVH

// Bits of a task ID and of a physical core ID.
`define OFLOW_KEY_WIDTH 4

// Number of tracked tasks.
`define OFLOW_KEY_SIZE 16

// Occupancy counters and maximum counts share this width.
`define OFLOW_COUNT_WIDTH 6

// Processor bus.
`define OFLOW_DATA_WIDTH 32
`define OFLOW_ADDR_WIDTH 32

`define OFLOW_REPORT_BASE 32'h0800_0000 // Start of the report region.
`define OFLOW_REPORT_MARKER 32'h0000_0200 // Added to every written record.

// One slot per task is enough to hold every pending report of one kind.
`define OFLOW_QUEUE_DEPTH `OFLOW_KEY_SIZE

`endif
